// ==== logic/dbg_pkg.sv ====
// Shared definitions for the RISC-V external debug subsystem
// DMI map, register layouts, hart-side request and response words, cmderr codes

`default_nettype none

package dbg_pkg;

	localparam int N_HARTS    = 2;
	localparam int XLEN       = 32;
	localparam int DMI_ADDR_W = 9;
	localparam int N_GPR      = 16;
	localparam int HART_IDX_W = $clog2(N_HARTS);
	localparam int GPR_IDX_W  = $clog2(N_GPR);
	localparam int HARTSEL_W  = 10;

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0040;

	// DM register addresses on the DMI
	localparam logic [DMI_ADDR_W-1:0] ADDR_DATA0      = 9'h04;
	localparam logic [DMI_ADDR_W-1:0] ADDR_DMCONTROL  = 9'h10;
	localparam logic [DMI_ADDR_W-1:0] ADDR_DMSTATUS   = 9'h11;
	localparam logic [DMI_ADDR_W-1:0] ADDR_HARTINFO   = 9'h12;
	localparam logic [DMI_ADDR_W-1:0] ADDR_ABSTRACTCS = 9'h16;
	localparam logic [DMI_ADDR_W-1:0] ADDR_COMMAND    = 9'h17;

	// Abstract register numbers
	localparam logic [15:0] REGNO_GPR0 = 16'h1000;
	localparam logic [15:0] REGNO_DPC  = 16'h07b1;

	localparam logic [2:0] CMDERR_NONE       = 3'd0;
	localparam logic [2:0] CMDERR_BUSY       = 3'd1;
	localparam logic [2:0] CMDERR_NOTSUP     = 3'd2;
	localparam logic [2:0] CMDERR_EXCEPTION  = 3'd3;
	localparam logic [2:0] CMDERR_HALTRESUME = 3'd4;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [DMI_ADDR_W-1:0] paddr;
		logic [XLEN-1:0]       pwdata;
	} dbg_dmi_req_t;

	typedef struct packed {
		logic [XLEN-1:0] prdata;
		logic            pready;
	} dbg_dmi_rsp_t;

	typedef struct packed {
		logic                 haltreq;
		logic                 resumereq;
		logic                 hartreset;
		logic [2:0]           rsvd_28_26;
		logic [HARTSEL_W-1:0] hartsello;
		logic [13:0]          rsvd_15_2;
		logic                 ndmreset;
		logic                 dmactive;
	} dbg_dmcontrol_t;

	// Access-register form of the command word, cmdtype 0
	typedef struct packed {
		logic [7:0]  cmdtype;
		logic        rsvd_23;
		logic [2:0]  aarsize;
		logic        aarpostincrement;
		logic        postexec;
		logic        transfer;
		logic        write;
		logic [15:0] regno;
	} dbg_command_t;

	typedef struct packed {
		logic halt_req;
		logic resume_req;
		logic reset_req;
	} dbg_hart_ctl_t;

	typedef struct packed {
		logic            valid;
		logic            write;
		logic [15:0]     regno;
		logic [XLEN-1:0] wdata;
	} dbg_acc_req_t;

	typedef struct packed {
		logic            halted;
		logic            running;
		logic            ack;
		logic            err;
		logic [XLEN-1:0] rdata;
	} dbg_hart_rsp_t;

endpackage

`default_nettype wire

// ==== logic/dbg_dm_regs.sv ====
// Debug module register file behind an APB-style DMI slave
// Holds dmcontrol and resumeack, builds dmstatus and abstractcs, drives hart control

`default_nettype none

module dbg_dm_regs (
	input  wire                                  clk,
	input  wire                                  i_rst,
	input  wire  dbg_pkg::dbg_dmi_req_t          i_dmi,
	output dbg_pkg::dbg_dmi_rsp_t                o_dmi,
	output dbg_pkg::dbg_hart_ctl_t               o_hart_ctl [dbg_pkg::N_HARTS],
	input  wire  dbg_pkg::dbg_hart_rsp_t         i_hart_rsp [dbg_pkg::N_HARTS],
	output logic                                 o_cmd_wen,
	output dbg_pkg::dbg_command_t                o_cmd,
	output logic [dbg_pkg::HARTSEL_W-1:0]        o_hartsel,
	output logic                                 o_data0_wen,
	output logic [dbg_pkg::XLEN-1:0]             o_data0_wdata,
	output logic [2:0]                           o_cmderr_clr,
	input  wire                                  i_busy,
	input  wire  [2:0]                           i_cmderr,
	input  wire  [dbg_pkg::XLEN-1:0]             i_data0
);

	dbg_pkg::dbg_dmcontrol_t dmcontrol;
	dbg_pkg::dbg_dmcontrol_t wr_ctl;
	dbg_pkg::dbg_dmcontrol_t ctl_next;

	logic                            dmi_access;
	logic                            dmi_wr;
	logic                            ctl_write;
	logic [dbg_pkg::N_HARTS-1:0]     resume_hit;
	logic [dbg_pkg::N_HARTS-1:0]     resume_q;
	logic [dbg_pkg::N_HARTS-1:0]     resumeack;
	logic                            sel_ok;
	logic [dbg_pkg::HART_IDX_W-1:0]  sel_idx;
	logic                            sel_halted;
	logic                            sel_running;
	logic                            sel_resack;
	logic [dbg_pkg::XLEN-1:0]        dmstatus;
	logic [dbg_pkg::XLEN-1:0]        abstractcs;
	logic [dbg_pkg::XLEN-1:0]        rdata;

	// Every access phase completes at once, so pready is just the access strobe
	assign dmi_access = i_dmi.psel && i_dmi.penable;
	assign dmi_wr     = dmi_access && i_dmi.pwrite;
	assign ctl_write  = dmi_wr && (i_dmi.paddr == dbg_pkg::ADDR_DMCONTROL);
	assign wr_ctl     = i_dmi.pwdata;

	// Fields other than dmactive only stick while the DM is active
	always_comb begin
		ctl_next          = '0;
		ctl_next.dmactive = wr_ctl.dmactive;
		if (wr_ctl.dmactive) begin
			ctl_next.haltreq   = wr_ctl.haltreq;
			ctl_next.hartreset = wr_ctl.hartreset;
			ctl_next.hartsello = wr_ctl.hartsello;
			ctl_next.ndmreset  = wr_ctl.ndmreset;
		end
	end

	// A resume is only passed on to a hart that is halted right now
	always_comb begin
		for (int h = 0; h < dbg_pkg::N_HARTS; h++) begin
			resume_hit[h] = ctl_write && wr_ctl.dmactive && wr_ctl.resumereq &&
				!wr_ctl.haltreq && (wr_ctl.hartsello == h) && i_hart_rsp[h].halted;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			dmcontrol <= '0;
			resume_q  <= '0;
			resumeack <= '0;
		end else begin
			if (ctl_write) begin
				dmcontrol <= ctl_next;
			end
			resume_q <= resume_hit;
			for (int h = 0; h < dbg_pkg::N_HARTS; h++) begin
				if (resume_hit[h]) begin
					resumeack[h] <= 1'b0;
				end else if (resume_q[h]) begin
					// The hart leaves halt at this same edge
					resumeack[h] <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int h = 0; h < dbg_pkg::N_HARTS; h++) begin
			o_hart_ctl[h].halt_req   = dmcontrol.haltreq && (dmcontrol.hartsello == h);
			o_hart_ctl[h].resume_req = resume_q[h];
			o_hart_ctl[h].reset_req  = dmcontrol.ndmreset ||
				(dmcontrol.hartreset && (dmcontrol.hartsello == h));
		end
	end

	assign sel_ok      = dmcontrol.hartsello < dbg_pkg::N_HARTS;
	assign sel_idx     = dmcontrol.hartsello[dbg_pkg::HART_IDX_W-1:0];
	assign sel_halted  = sel_ok && i_hart_rsp[sel_idx].halted;
	assign sel_running = sel_ok && i_hart_rsp[sel_idx].running;
	assign sel_resack  = sel_ok && resumeack[sel_idx];

	// Only one hart is ever selected, so the any and all bits always agree
	always_comb begin
		dmstatus        = '0;
		dmstatus[3:0]   = 4'd2;
		dmstatus[7]     = 1'b1;
		dmstatus[9:8]   = {2{sel_halted}};
		dmstatus[11:10] = {2{sel_running}};
		dmstatus[15:14] = {2{!sel_ok}};
		dmstatus[17:16] = {2{sel_resack}};
	end

	always_comb begin
		abstractcs        = '0;
		abstractcs[3:0]   = 4'd1;
		abstractcs[10:8]  = i_cmderr;
		abstractcs[12]    = i_busy;
	end

	always_comb begin
		case (i_dmi.paddr)
			dbg_pkg::ADDR_DATA0:      rdata = i_data0;
			dbg_pkg::ADDR_DMCONTROL:  rdata = dmcontrol;
			dbg_pkg::ADDR_DMSTATUS:   rdata = dmstatus;
			dbg_pkg::ADDR_HARTINFO:   rdata = '0;
			dbg_pkg::ADDR_ABSTRACTCS: rdata = abstractcs;
			default:                  rdata = '0;
		endcase
	end

	assign o_dmi.prdata = rdata;
	assign o_dmi.pready = dmi_access;

	// Strobes towards the command engine
	assign o_cmd_wen     = dmi_wr && dmcontrol.dmactive &&
		(i_dmi.paddr == dbg_pkg::ADDR_COMMAND);
	assign o_cmd         = i_dmi.pwdata;
	assign o_hartsel     = dmcontrol.hartsello;
	assign o_data0_wen   = dmi_wr && dmcontrol.dmactive &&
		(i_dmi.paddr == dbg_pkg::ADDR_DATA0);
	assign o_data0_wdata = i_dmi.pwdata;
	assign o_cmderr_clr  = (dmi_wr && (i_dmi.paddr == dbg_pkg::ADDR_ABSTRACTCS)) ?
		i_dmi.pwdata[10:8] : 3'b000;

endmodule

`default_nettype wire

// ==== logic/dbg_abstract_cmd.sv ====
// Abstract command engine for access-register commands
// Checks each command, runs one access on the selected hart and keeps data0 and cmderr

`default_nettype none

module dbg_abstract_cmd (
	input  wire                                  clk,
	input  wire                                  i_rst,
	input  wire                                  i_cmd_wen,
	input  wire  dbg_pkg::dbg_command_t          i_cmd,
	input  wire  [dbg_pkg::HARTSEL_W-1:0]        i_hartsel,
	input  wire                                  i_data0_wen,
	input  wire  [dbg_pkg::XLEN-1:0]             i_data0_wdata,
	input  wire  [2:0]                           i_cmderr_clr,
	input  wire  dbg_pkg::dbg_hart_rsp_t         i_hart_rsp [dbg_pkg::N_HARTS],
	output dbg_pkg::dbg_acc_req_t                o_acc [dbg_pkg::N_HARTS],
	output logic                                 o_busy,
	output logic [2:0]                           o_cmderr,
	output logic [dbg_pkg::XLEN-1:0]             o_data0
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT
	} state_t;

	state_t                          state;
	logic                            xfer_q;
	logic                            write_q;
	logic [15:0]                     regno_q;
	logic [dbg_pkg::HART_IDX_W-1:0]  hart_q;
	logic [dbg_pkg::HART_IDX_W-1:0]  sel_idx;
	logic                            sel_halted;
	logic                            cmd_notsup;
	logic [2:0]                      chk_err;
	logic                            rsp_done;
	logic [2:0]                      new_err;
	dbg_pkg::dbg_hart_rsp_t          rsp;

	assign o_busy     = state != ST_IDLE;
	assign sel_idx    = i_hartsel[dbg_pkg::HART_IDX_W-1:0];
	assign sel_halted = (i_hartsel < dbg_pkg::N_HARTS) && i_hart_rsp[sel_idx].halted;
	assign cmd_notsup = (i_cmd.cmdtype != 8'd0) || (i_cmd.aarsize != 3'd2) ||
		i_cmd.postexec || i_cmd.aarpostincrement;

	// The order of these checks sets which error wins
	always_comb begin
		if (o_busy) begin
			chk_err = dbg_pkg::CMDERR_BUSY;
		end else if (cmd_notsup) begin
			chk_err = dbg_pkg::CMDERR_NOTSUP;
		end else if (!sel_halted) begin
			chk_err = dbg_pkg::CMDERR_HALTRESUME;
		end else begin
			chk_err = dbg_pkg::CMDERR_NONE;
		end
	end

	assign rsp      = i_hart_rsp[hart_q];
	assign rsp_done = (state == ST_WAIT) && xfer_q && rsp.ack;

	always_comb begin
		if (i_cmd_wen && (chk_err != dbg_pkg::CMDERR_NONE)) begin
			new_err = chk_err;
		end else if (rsp_done && rsp.err) begin
			new_err = dbg_pkg::CMDERR_EXCEPTION;
		end else begin
			new_err = dbg_pkg::CMDERR_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state    <= ST_IDLE;
			o_cmderr <= dbg_pkg::CMDERR_NONE;
			o_data0  <= '0;
		end else begin
			case (state)
				ST_IDLE:  state <= (i_cmd_wen && (chk_err == dbg_pkg::CMDERR_NONE)) ?
					ST_ISSUE : ST_IDLE;
				ST_ISSUE: state <= ST_WAIT;
				default:  state <= ST_IDLE;
			endcase
			// An error already standing is kept until the debugger clears it
			if ((new_err != dbg_pkg::CMDERR_NONE) && (o_cmderr == dbg_pkg::CMDERR_NONE)) begin
				o_cmderr <= new_err;
			end else begin
				o_cmderr <= o_cmderr & ~i_cmderr_clr;
			end
			if (rsp_done && !rsp.err && !write_q) begin
				o_data0 <= rsp.rdata;
			end else if (i_data0_wen && !o_busy) begin
				o_data0 <= i_data0_wdata;
			end
		end
	end

	// Command fields are latched once at the accepting write
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && i_cmd_wen) begin
			xfer_q  <= i_cmd.transfer;
			write_q <= i_cmd.write;
			regno_q <= i_cmd.regno;
			hart_q  <= sel_idx;
		end
	end

	always_comb begin
		for (int h = 0; h < dbg_pkg::N_HARTS; h++) begin
			o_acc[h].valid = (state == ST_ISSUE) && xfer_q && (hart_q == h);
			o_acc[h].write = write_q;
			o_acc[h].regno = regno_q;
			o_acc[h].wdata = o_data0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/dbg_hart_shell.sv ====
// Debug-facing shell of one hart, in place of a CPU core
// Reset synchroniser, run/halt state, a free-running dpc and a GPR file for abstract access

`default_nettype none

module dbg_hart_shell (
	input  wire                           clk,
	input  wire                           i_rst,
	input  wire  dbg_pkg::dbg_hart_ctl_t  i_ctl,
	input  wire  dbg_pkg::dbg_acc_req_t   i_acc,
	output dbg_pkg::dbg_hart_rsp_t        o_rsp
);

	logic [1:0]                     rst_pipe;
	logic                           hart_rst;
	logic                           halted;
	logic [dbg_pkg::XLEN-1:0]       dpc;
	logic [dbg_pkg::XLEN-1:0]       gpr [dbg_pkg::N_GPR];
	logic [15:0]                    gpr_off;
	logic [dbg_pkg::GPR_IDX_W-1:0]  gpr_idx;
	logic                           is_gpr;
	logic                           is_dpc;
	logic                           ack;
	logic                           err;
	logic [dbg_pkg::XLEN-1:0]       rdata;

	// System reset asserts at once; any release goes through both flops
	always_ff @(posedge clk) begin
		if (i_rst) begin
			rst_pipe <= 2'b11;
		end else begin
			rst_pipe <= {rst_pipe[0], i_ctl.reset_req};
		end
	end

	assign hart_rst = rst_pipe[1];

	always_ff @(posedge clk) begin
		if (hart_rst) begin
			halted <= 1'b0;
			dpc    <= dbg_pkg::RESET_PC;
		end else if (halted) begin
			if (i_ctl.resume_req) begin
				halted <= 1'b0;
			end
		end else if (i_ctl.halt_req) begin
			halted <= 1'b1;
		end else begin
			// Stand-in for instruction fetch while running
			dpc <= dpc + 32'd4;
		end
	end

	// Below REGNO_GPR0 the offset wraps high, so one compare covers both ends
	assign gpr_off = i_acc.regno - dbg_pkg::REGNO_GPR0;
	assign is_gpr  = gpr_off < dbg_pkg::N_GPR;
	assign gpr_idx = gpr_off[dbg_pkg::GPR_IDX_W-1:0];
	assign is_dpc  = i_acc.regno == dbg_pkg::REGNO_DPC;

	always_ff @(posedge clk) begin
		if (hart_rst) begin
			ack <= 1'b0;
			err <= 1'b0;
			for (int i = 0; i < dbg_pkg::N_GPR; i++) begin
				gpr[i] <= '0;
			end
		end else begin
			ack <= i_acc.valid;
			if (i_acc.valid) begin
				err <= !(is_gpr || is_dpc) || (is_dpc && i_acc.write);
				// x0 is never written, so it keeps the zero from reset
				if (is_gpr && i_acc.write && (gpr_idx != '0)) begin
					gpr[gpr_idx] <= i_acc.wdata;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_acc.valid) begin
			if (is_dpc) begin
				rdata <= dpc;
			end else if (is_gpr) begin
				rdata <= gpr[gpr_idx];
			end else begin
				rdata <= '0;
			end
		end
	end

	assign o_rsp.halted  = halted;
	assign o_rsp.running = !halted && !hart_rst;
	assign o_rsp.ack     = ack;
	assign o_rsp.err     = err;
	assign o_rsp.rdata   = rdata;

endmodule

`default_nettype wire

// ==== logic/dbg_subsys_top.sv ====
// Debug subsystem top: DM registers and command engine driving two hart shells
// The debug transport reaches it over the APB-style DMI

`default_nettype none

module dbg_subsys_top (
	input  wire                          clk,
	input  wire                          i_rst,
	input  wire  dbg_pkg::dbg_dmi_req_t  i_dmi,
	output dbg_pkg::dbg_dmi_rsp_t        o_dmi
);

	wire dbg_pkg::dbg_hart_ctl_t  hart_ctl [dbg_pkg::N_HARTS];
	wire dbg_pkg::dbg_hart_rsp_t  hart_rsp [dbg_pkg::N_HARTS];
	wire dbg_pkg::dbg_acc_req_t   hart_acc [dbg_pkg::N_HARTS];

	wire                            cmd_wen;
	wire dbg_pkg::dbg_command_t     cmd;
	wire [dbg_pkg::HARTSEL_W-1:0]   hartsel;
	wire                            data0_wen;
	wire [dbg_pkg::XLEN-1:0]        data0_wdata;
	wire [2:0]                      cmderr_clr;
	wire                            busy;
	wire [2:0]                      cmderr;
	wire [dbg_pkg::XLEN-1:0]        data0;

	dbg_dm_regs u_dm_regs (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_dmi         (i_dmi),
		.o_dmi         (o_dmi),
		.o_hart_ctl    (hart_ctl),
		.i_hart_rsp    (hart_rsp),
		.o_cmd_wen     (cmd_wen),
		.o_cmd         (cmd),
		.o_hartsel     (hartsel),
		.o_data0_wen   (data0_wen),
		.o_data0_wdata (data0_wdata),
		.o_cmderr_clr  (cmderr_clr),
		.i_busy        (busy),
		.i_cmderr      (cmderr),
		.i_data0       (data0)
	);

	dbg_abstract_cmd u_abstract_cmd (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_cmd_wen     (cmd_wen),
		.i_cmd         (cmd),
		.i_hartsel     (hartsel),
		.i_data0_wen   (data0_wen),
		.i_data0_wdata (data0_wdata),
		.i_cmderr_clr  (cmderr_clr),
		.i_hart_rsp    (hart_rsp),
		.o_acc         (hart_acc),
		.o_busy        (busy),
		.o_cmderr      (cmderr),
		.o_data0       (data0)
	);

	// One shell per hart, each with its own reset synchroniser
	for (genvar h = 0; h < dbg_pkg::N_HARTS; h++) begin : g_hart
		dbg_hart_shell u_hart_shell (
			.clk   (clk),
			.i_rst (i_rst),
			.i_ctl (hart_ctl[h]),
			.i_acc (hart_acc[h]),
			.o_rsp (hart_rsp[h])
		);
	end

endmodule

`default_nettype wire

// ==== dv/dbg_tb.sv ====
// Directed testbench for the RISC-V debug subsystem
// Acts as DMI master and checks the DM registers, command engine and hart shells

`default_nettype none

module dbg_tb;

	// The directed sequence runs for roughly 380 cycles of DMI traffic
	localparam int TIMEOUT_CYCLES = 400;
	localparam int POLL_LIMIT     = 8;

	logic                   clk;
	logic                   i_rst;
	dbg_pkg::dbg_dmi_req_t  dmi_req;
	dbg_pkg::dbg_dmi_rsp_t  dmi_rsp;
	int                     cycle_count;
	logic [dbg_pkg::XLEN-1:0] gpr_vals [dbg_pkg::N_GPR];

	dbg_subsys_top u_dbg_subsys_top (
		.clk   (clk),
		.i_rst (i_rst),
		.i_dmi (dmi_req),
		.o_dmi (dmi_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		stop_on_error("Timeout: the tests did not finish within the cycle limit");
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [dbg_pkg::XLEN-1:0] got,
		input logic [dbg_pkg::XLEN-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_cmderr(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
		end
	endtask

	// Inputs change a little after each rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic dmi_write(input logic [dbg_pkg::DMI_ADDR_W-1:0] addr,
		input logic [dbg_pkg::XLEN-1:0] data);
		dmi_req.psel    = 1'b1;
		dmi_req.penable = 1'b0;
		dmi_req.pwrite  = 1'b1;
		dmi_req.paddr   = addr;
		dmi_req.pwdata  = data;
		next_cycle();
		dmi_req.penable = 1'b1;
		#10;
		if (!dmi_rsp.pready) begin
			stop_on_error("The DM did not raise pready in a write access cycle");
		end
		next_cycle();
		dmi_req.psel    = 1'b0;
		dmi_req.penable = 1'b0;
	endtask

	task automatic dmi_read(input logic [dbg_pkg::DMI_ADDR_W-1:0] addr,
		output logic [dbg_pkg::XLEN-1:0] data);
		dmi_req.psel    = 1'b1;
		dmi_req.penable = 1'b0;
		dmi_req.pwrite  = 1'b0;
		dmi_req.paddr   = addr;
		dmi_req.pwdata  = '0;
		next_cycle();
		dmi_req.penable = 1'b1;
		#10;
		if (!dmi_rsp.pready) begin
			stop_on_error("The DM did not raise pready in a read access cycle");
		end
		data = dmi_rsp.prdata;
		next_cycle();
		dmi_req.psel    = 1'b0;
		dmi_req.penable = 1'b0;
	endtask

	task automatic write_ctl(input int hartsel, input logic haltreq, input logic resumereq,
		input logic hartreset, input logic ndmreset);
		dbg_pkg::dbg_dmcontrol_t ctl;
		ctl           = '0;
		ctl.dmactive  = 1'b1;
		ctl.haltreq   = haltreq;
		ctl.resumereq = resumereq;
		ctl.hartreset = hartreset;
		ctl.ndmreset  = ndmreset;
		ctl.hartsello = 10'(hartsel);
		dmi_write(dbg_pkg::ADDR_DMCONTROL, ctl);
	endtask

	// Polls dmstatus until the given bit is set for the selected hart
	task automatic poll_status(input int bit_idx, input string what,
		output logic [dbg_pkg::XLEN-1:0] st);
		int polls;
		dmi_read(dbg_pkg::ADDR_DMSTATUS, st);
		polls = 1;
		while (!st[bit_idx]) begin
			if (polls == POLL_LIMIT) begin
				stop_on_error(what);
			end else begin
				dmi_read(dbg_pkg::ADDR_DMSTATUS, st);
				polls++;
			end
		end
	endtask

	task automatic wait_idle(output logic [dbg_pkg::XLEN-1:0] cs);
		int polls;
		next_cycle();
		dmi_read(dbg_pkg::ADDR_ABSTRACTCS, cs);
		polls = 1;
		while (cs[12]) begin
			if (polls == POLL_LIMIT) begin
				stop_on_error("The abstract command engine stayed busy");
			end else begin
				dmi_read(dbg_pkg::ADDR_ABSTRACTCS, cs);
				polls++;
			end
		end
	endtask

	task automatic send_command(input logic wr, input logic [15:0] regno,
		input logic [2:0] aarsize);
		dbg_pkg::dbg_command_t cmd;
		cmd          = '0;
		cmd.aarsize  = aarsize;
		cmd.transfer = 1'b1;
		cmd.write    = wr;
		cmd.regno    = regno;
		dmi_write(dbg_pkg::ADDR_COMMAND, cmd);
	endtask

	task automatic clear_cmderr();
		dmi_write(dbg_pkg::ADDR_ABSTRACTCS, 32'h0000_0700);
	endtask

	task automatic write_reg(input logic [15:0] regno, input logic [dbg_pkg::XLEN-1:0] data);
		logic [dbg_pkg::XLEN-1:0] cs;
		dmi_write(dbg_pkg::ADDR_DATA0, data);
		send_command(1'b1, regno, 3'd2);
		wait_idle(cs);
		check_cmderr("abstractcs.cmderr", cs[10:8], dbg_pkg::CMDERR_NONE);
	endtask

	task automatic read_reg(input logic [15:0] regno, output logic [dbg_pkg::XLEN-1:0] data);
		logic [dbg_pkg::XLEN-1:0] cs;
		send_command(1'b0, regno, 3'd2);
		wait_idle(cs);
		check_cmderr("abstractcs.cmderr", cs[10:8], dbg_pkg::CMDERR_NONE);
		dmi_read(dbg_pkg::ADDR_DATA0, data);
	endtask

	// A rejected command must leave busy low and record the error at once
	task automatic expect_reject(input logic [2:0] exp);
		logic [dbg_pkg::XLEN-1:0] cs;
		dmi_read(dbg_pkg::ADDR_ABSTRACTCS, cs);
		check_cmderr("abstractcs.cmderr", cs[10:8], exp);
		check_word("abstractcs.busy", cs[12], 1'b0);
		clear_cmderr();
	endtask

	task automatic test_status();
		logic [dbg_pkg::XLEN-1:0] st;
		write_ctl(0, 1'b0, 1'b0, 1'b0, 1'b0);
		dmi_read(dbg_pkg::ADDR_DMSTATUS, st);
		check_word("dmstatus.version", st[3:0], 4'd2);
		check_word("dmstatus.authenticated", st[7], 1'b1);
		check_word("dmstatus.allrunning hart 0", st[11:10], 2'b11);
		write_ctl(1, 1'b0, 1'b0, 1'b0, 1'b0);
		dmi_read(dbg_pkg::ADDR_DMSTATUS, st);
		check_word("dmstatus.allrunning hart 1", st[11:10], 2'b11);
		write_ctl(5, 1'b0, 1'b0, 1'b0, 1'b0);
		dmi_read(dbg_pkg::ADDR_DMSTATUS, st);
		check_word("dmstatus.allnonexistent", st[15:14], 2'b11);
		check_word("dmstatus.allrunning hart 5", st[11:10], 2'b00);
	endtask

	task automatic test_halt_resume();
		logic [dbg_pkg::XLEN-1:0] st;
		write_ctl(1, 1'b1, 1'b0, 1'b0, 1'b0);
		poll_status(9, "Hart 1 did not halt", st);
		check_word("dmstatus.allhalted hart 1", st[9:8], 2'b11);
		write_ctl(0, 1'b0, 1'b0, 1'b0, 1'b0);
		dmi_read(dbg_pkg::ADDR_DMSTATUS, st);
		check_word("dmstatus.allrunning hart 0", st[11:10], 2'b11);
		write_ctl(1, 1'b0, 1'b1, 1'b0, 1'b0);
		poll_status(17, "Hart 1 did not acknowledge the resume", st);
		check_word("dmstatus.allresumeack", st[17:16], 2'b11);
		check_word("dmstatus.allrunning hart 1", st[11:10], 2'b11);
		// Hart 1 stays halted for the register tests that follow
		write_ctl(1, 1'b1, 1'b0, 1'b0, 1'b0);
		poll_status(9, "Hart 1 did not halt again", st);
	endtask

	task automatic test_gpr_access();
		logic [dbg_pkg::XLEN-1:0] rd;
		logic [dbg_pkg::XLEN-1:0] dpc_first;
		// x0 takes a write like any GPR but must still read zero
		rd = $urandom() | 32'h1;
		write_reg(dbg_pkg::REGNO_GPR0, rd);
		for (int i = 1; i < dbg_pkg::N_GPR; i++) begin
			gpr_vals[i] = $urandom();
			write_reg(dbg_pkg::REGNO_GPR0 + 16'(i), gpr_vals[i]);
		end
		for (int i = 1; i < dbg_pkg::N_GPR; i++) begin
			read_reg(dbg_pkg::REGNO_GPR0 + 16'(i), rd);
			check_word($sformatf("hart 1 x%0d", i), rd, gpr_vals[i]);
		end
		read_reg(dbg_pkg::REGNO_GPR0, rd);
		check_word("hart 1 x0", rd, '0);
		// A halted hart keeps its dpc frozen
		read_reg(dbg_pkg::REGNO_DPC, dpc_first);
		read_reg(dbg_pkg::REGNO_DPC, rd);
		check_word("hart 1 dpc second read", rd, dpc_first);
	endtask

	task automatic test_cmd_errors();
		logic [dbg_pkg::XLEN-1:0] cs;
		write_ctl(0, 1'b0, 1'b0, 1'b0, 1'b0);
		send_command(1'b0, dbg_pkg::REGNO_GPR0 + 16'd1, 3'd2);
		expect_reject(dbg_pkg::CMDERR_HALTRESUME);
		write_ctl(1, 1'b1, 1'b0, 1'b0, 1'b0);
		send_command(1'b0, dbg_pkg::REGNO_GPR0 + 16'd1, 3'd3);
		expect_reject(dbg_pkg::CMDERR_NOTSUP);
		send_command(1'b0, 16'h1010, 3'd2);
		wait_idle(cs);
		check_cmderr("abstractcs.cmderr", cs[10:8], dbg_pkg::CMDERR_EXCEPTION);
		clear_cmderr();
		// The second command lands while the first is still in flight
		send_command(1'b0, dbg_pkg::REGNO_GPR0 + 16'd1, 3'd2);
		send_command(1'b0, dbg_pkg::REGNO_GPR0 + 16'd2, 3'd2);
		wait_idle(cs);
		check_cmderr("abstractcs.cmderr", cs[10:8], dbg_pkg::CMDERR_BUSY);
		clear_cmderr();
		dmi_read(dbg_pkg::ADDR_ABSTRACTCS, cs);
		check_cmderr("abstractcs.cmderr", cs[10:8], dbg_pkg::CMDERR_NONE);
	endtask

	task automatic test_hart_reset();
		logic [dbg_pkg::XLEN-1:0] st;
		logic [dbg_pkg::XLEN-1:0] rd;
		// Hart 0 gets nonzero registers so the reset has something to clear
		write_ctl(0, 1'b1, 1'b0, 1'b0, 1'b0);
		poll_status(9, "Hart 0 did not halt", st);
		write_reg(dbg_pkg::REGNO_GPR0 + 16'd1, 32'h5a5a_0001);
		write_reg(dbg_pkg::REGNO_GPR0 + 16'd15, 32'ha5a5_000f);
		write_ctl(0, 1'b0, 1'b0, 1'b1, 1'b0);
		write_ctl(0, 1'b0, 1'b0, 1'b0, 1'b0);
		write_ctl(0, 1'b1, 1'b0, 1'b0, 1'b0);
		poll_status(9, "Hart 0 did not halt after hartreset", st);
		read_reg(dbg_pkg::REGNO_GPR0 + 16'd1, rd);
		check_word("hart 0 x1 after hartreset", rd, '0);
		read_reg(dbg_pkg::REGNO_GPR0 + 16'd15, rd);
		check_word("hart 0 x15 after hartreset", rd, '0);
		read_reg(dbg_pkg::REGNO_DPC, rd);
		check_word("hart 0 dpc after hartreset", rd, dbg_pkg::RESET_PC);
		write_ctl(1, 1'b1, 1'b0, 1'b0, 1'b0);
		read_reg(dbg_pkg::REGNO_GPR0 + 16'd5, rd);
		check_word("hart 1 x5 kept", rd, gpr_vals[5]);
		write_ctl(1, 1'b0, 1'b0, 1'b0, 1'b1);
		write_ctl(1, 1'b0, 1'b0, 1'b0, 1'b0);
		write_ctl(1, 1'b1, 1'b0, 1'b0, 1'b0);
		poll_status(9, "Hart 1 did not halt after ndmreset", st);
		read_reg(dbg_pkg::REGNO_GPR0 + 16'd5, rd);
		check_word("hart 1 x5 after ndmreset", rd, '0);
		// Hart 0 was halted before ndmreset and must be running now
		write_ctl(0, 1'b0, 1'b0, 1'b0, 1'b0);
		dmi_read(dbg_pkg::ADDR_DMSTATUS, st);
		check_word("dmstatus.allrunning hart 0 after ndmreset", st[11:10], 2'b11);
	endtask

	initial begin
		void'($urandom(32'h4642));
		i_rst   = 1'b1;
		dmi_req = '0;
		for (int i = 0; i < dbg_pkg::N_GPR; i++) begin
			gpr_vals[i] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		i_rst = 1'b0;
		test_status();
		test_halt_resume();
		test_gpr_access();
		test_cmd_errors();
		test_hart_reset();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/dbg_pkg.sv
logic/dbg_dm_regs.sv
logic/dbg_abstract_cmd.sv
logic/dbg_hart_shell.sv
logic/dbg_subsys_top.sv
dv/dbg_tb.sv
